//--- hw/nodePkg.sv
// node side view of the network
// fields the node keeps about itself and its neighbors
package nodePkg;

    // node address on air
    typedef logic [15:0] nodeIdT;

    // hop distance, towards sink or towards cluster head
    typedef logic [15:0] hopCountT;

    // learned routing value
    typedef logic [15:0] qValueT;

    // residual battery energy
    typedef logic [15:0] energyT;

    // destination of every rippled packet
    localparam nodeIdT BROADCAST_ID = 16'hFFFF;

    // the sink always sits at address zero
    localparam nodeIdT SINK_ID = 16'h0000;

    // idle cycles after a heartbeat before a membership request goes out
    localparam logic [15:0] TIMEOUT_RELOAD = 16'd10;

endpackage

//--- hw/packetPkg.sv
// packet level encodings
// on-air types, packer decisions, controller states, flow control
package packetPkg;

    // 3-bit type field of the packet header
    typedef enum logic [2:0] {
        HB      = 3'b000,
        CHE     = 3'b001,
        INV     = 3'b010,
        MR      = 3'b011,
        CHT     = 3'b100,
        DATA    = 3'b101,
        SOS     = 3'b110,
        INVALID = 3'b111
    } pktTypeE;

    // what the packer does with the source it serves
    typedef enum logic [2:0] {
        NONE,
        DROP,
        HB_RIPPLE,
        INV_RIPPLE,
        MEMBER_REQ,
        FORWARD,
        OWN_DATA
    } pktKindE;

    // sequencing of one outgoing packet
    typedef enum logic [1:0] {
        IDLE,
        BUILD,
        SEND
    } ctrlStateE;

    // invitations ripple only below this hop count
    localparam int unsigned INV_HOP_LIMIT = 4;

    // transmitter credits after reset
    localparam int unsigned TX_CREDITS   = 2;
    localparam int unsigned CREDIT_WIDTH = $clog2(TX_CREDITS + 1);

    // transmitter credit count
    typedef logic [CREDIT_WIDTH-1:0] creditT;

endpackage

//--- hw/membershipTimer.sv
`timescale 1ns/100ps

module membershipTimer
    import nodePkg::*;
(
    input  logic clk,
    input  logic nrst,
    input  logic idle,
    input  logic hbSeen,
    input  logic reload,
    output logic expired
);

    // idle cycles left before the membership request
    logic [$bits(TIMEOUT_RELOAD)-1:0] count;
    logic                             counting;

    // only count while nothing is in flight and a heartbeat came by
    assign counting = idle && hbSeen;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= TIMEOUT_RELOAD;
        end else if (reload || !counting) begin
            // request taken, busy, or no heartbeat yet
            count <= TIMEOUT_RELOAD;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // stays high until the controller takes the request
    assign expired = (count == '0);

endmodule

//--- hw/packetClassifier.sv
`timescale 1ns/100ps

module packetClassifier
    import nodePkg::*, packetPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     rxValid,
    input  pktTypeE  rxType,
    input  nodeIdT   rxSourceID,
    input  hopCountT rxSourceHops,
    input  qValueT   rxQValue,
    input  energyT   rxEnergy,
    input  hopCountT rxHopsFromCH,
    input  nodeIdT   rxChosenCH,
    input  logic     iAmDestination,
    input  logic     iHaveData,
    input  logic     expired,
    input  logic     take,
    output pktKindE  kind,
    output logic     hbSeen,
    output pktTypeE  heldType,
    output nodeIdT   heldSourceID,
    output hopCountT heldSourceHops,
    output qValueT   heldQValue,
    output energyT   heldEnergy,
    output hopCountT heldHopsFromCH,
    output nodeIdT   heldChosenCH
);

    logic heldValid;
    logic heldForMe;
    logic ownPending;
    logic hbLock;
    logic rxServed;

    // take of a kind that came from the held event
    assign rxServed = take && (kind inside {DROP, HB_RIPPLE, INV_RIPPLE, FORWARD});

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            heldValid  <= 1'b0;
            ownPending <= 1'b0;
            hbLock     <= 1'b0;
        end else begin
            // one upstream credit, so capture never meets a held event
            if (rxValid) begin
                heldValid <= 1'b1;
            end else if (rxServed) begin
                heldValid <= 1'b0;
            end
            // a fresh request in the take cycle keeps the flag up
            if (iHaveData) begin
                ownPending <= 1'b1;
            end else if (take && kind == OWN_DATA) begin
                ownPending <= 1'b0;
            end
            // data seen means a new round, so next heartbeat ripples again
            if (take && kind == HB_RIPPLE) begin
                hbLock <= 1'b1;
            end else if (rxServed && heldType == DATA) begin
                hbLock <= 1'b0;
            end
        end
    end

    // received header fields
    always_ff @(posedge clk) begin
        if (rxValid) begin
            heldType       <= rxType;
            heldSourceID   <= rxSourceID;
            heldSourceHops <= rxSourceHops;
            heldQValue     <= rxQValue;
            heldEnergy     <= rxEnergy;
            heldHopsFromCH <= rxHopsFromCH;
            heldChosenCH   <= rxChosenCH;
            heldForMe      <= iAmDestination;
        end
    end

    // priority: timeout, held event, own data
    always_comb begin
        if (expired) begin
            kind = MEMBER_REQ;
        end else if (heldValid) begin
            case (heldType)
                HB:        kind = hbLock ? DROP : HB_RIPPLE;
                INV:       kind = (heldHopsFromCH < hopCountT'(INV_HOP_LIMIT)) ? INV_RIPPLE : DROP;
                DATA, SOS: kind = heldForMe ? FORWARD : DROP;
                default:   kind = DROP;
            endcase
        end else if (ownPending) begin
            kind = OWN_DATA;
        end else begin
            kind = NONE;
        end
    end

    assign hbSeen = hbLock;

endmodule

//--- hw/headerBuilder.sv
`timescale 1ns/100ps

module headerBuilder
    import nodePkg::*, packetPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     load,
    input  pktKindE  kind,
    input  pktTypeE  heldType,
    input  nodeIdT   heldSourceID,
    input  hopCountT heldSourceHops,
    input  qValueT   heldQValue,
    input  energyT   heldEnergy,
    input  hopCountT heldHopsFromCH,
    input  nodeIdT   heldChosenCH,
    input  nodeIdT   myNodeID,
    input  energyT   myEnergy,
    input  qValueT   myQValue,
    input  hopCountT hopsFromSink,
    input  hopCountT hopsFromCH,
    input  nodeIdT   chosenCH,
    input  nodeIdT   chosenHop,
    input  logic     lowEnergy,
    output pktTypeE  pktType,
    output nodeIdT   pktSourceID,
    output hopCountT pktSourceHops,
    output qValueT   pktQValue,
    output energyT   pktEnergy,
    output hopCountT pktHopsFromCH,
    output nodeIdT   pktChosenCH,
    output nodeIdT   pktDestID,
    output logic     txPower
);

    // kind is gone from the classifier once taken, keep our own copy
    pktKindE  kindQ;
    logic     buildQ;
    nodeIdT   nextHop;
    pktTypeE  typeN;
    nodeIdT   sourceN;
    hopCountT sourceHopsN;
    qValueT   qValueN;
    energyT   energyN;
    hopCountT hopsFromCHN;
    nodeIdT   chosenCHN;
    nodeIdT   destN;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            kindQ  <= NONE;
            buildQ <= 1'b0;
        end else begin
            buildQ <= load;
            if (load) begin
                kindQ <= kind;
            end
        end
    end

    // one hop from the sink talks to it directly
    assign nextHop = (hopsFromSink == hopCountT'(1)) ? SINK_ID : chosenHop;

    always_comb begin
        // own identity unless the kind says otherwise
        typeN       = INVALID;
        sourceN     = myNodeID;
        sourceHopsN = hopsFromSink;
        qValueN     = myQValue;
        energyN     = myEnergy;
        hopsFromCHN = hopsFromCH;
        chosenCHN   = chosenCH;
        destN       = nextHop;
        case (kindQ)
            HB_RIPPLE: begin
                typeN       = HB;
                sourceN     = heldSourceID;
                sourceHopsN = hopsFromSink + hopCountT'(1);
                qValueN     = heldQValue;
                energyN     = heldEnergy;
                hopsFromCHN = heldHopsFromCH;
                chosenCHN   = heldChosenCH;
                destN       = BROADCAST_ID;
            end
            INV_RIPPLE: begin
                typeN       = INV;
                sourceN     = heldSourceID;
                sourceHopsN = heldSourceHops;
                qValueN     = heldQValue;
                energyN     = heldEnergy;
                hopsFromCHN = heldHopsFromCH + hopCountT'(1);
                chosenCHN   = heldChosenCH;
                destN       = BROADCAST_ID;
            end
            FORWARD: begin
                // passed on untouched, only the destination changes
                typeN       = heldType;
                sourceN     = heldSourceID;
                sourceHopsN = heldSourceHops;
                qValueN     = heldQValue;
                energyN     = heldEnergy;
                hopsFromCHN = heldHopsFromCH;
                chosenCHN   = heldChosenCH;
            end
            MEMBER_REQ: begin
                typeN = MR;
                destN = chosenCH;
            end
            OWN_DATA: begin
                typeN = lowEnergy ? SOS : DATA;
            end
            default: begin
                typeN = INVALID;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pktType       <= INVALID;
            pktSourceID   <= '0;
            pktSourceHops <= '0;
            pktQValue     <= '0;
            pktEnergy     <= '0;
            pktHopsFromCH <= '0;
            pktChosenCH   <= '0;
            pktDestID     <= BROADCAST_ID;
            txPower       <= 1'b0;
        end else if (buildQ) begin
            pktType       <= typeN;
            pktSourceID   <= sourceN;
            pktSourceHops <= sourceHopsN;
            pktQValue     <= qValueN;
            pktEnergy     <= energyN;
            pktHopsFromCH <= hopsFromCHN;
            pktChosenCH   <= chosenCHN;
            pktDestID     <= destN;
            // long range only for a request to a far cluster head
            txPower       <= (kindQ == MEMBER_REQ) && (hopsFromCH > hopCountT'(1));
        end
    end

endmodule

//--- hw/rewardCtrl.sv
`timescale 1ns/100ps

module rewardCtrl
    import packetPkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  pktKindE kind,
    input  logic    txCredit,
    output logic    take,
    output logic    load,
    output logic    idle,
    output logic    pktValid,
    output logic    rxCredit
);

    ctrlStateE state;
    creditT    credits;
    // packet in flight owes the filter its credit
    logic      rxOrigin;
    logic      dropDone;
    logic      sendKind;
    logic      rxKind;

    assign sendKind = kind inside {HB_RIPPLE, INV_RIPPLE, MEMBER_REQ, FORWARD, OWN_DATA};
    assign rxKind   = kind inside {HB_RIPPLE, INV_RIPPLE, FORWARD};

    assign idle     = (state == IDLE);
    // a drop is consumed right here, without a build
    assign take     = idle && (kind != NONE);
    assign load     = idle && sendKind;
    assign pktValid = (state == SEND) && (credits != '0);
    assign rxCredit = dropDone || (pktValid && rxOrigin);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state    <= IDLE;
            rxOrigin <= 1'b0;
            dropDone <= 1'b0;
        end else begin
            dropDone <= idle && (kind == DROP);
            case (state)
                IDLE: begin
                    if (sendKind) begin
                        state    <= BUILD;
                        rxOrigin <= rxKind;
                    end
                end
                // header lands in the builder here
                BUILD: state <= SEND;
                SEND: begin
                    // hold the header until the transmitter has room
                    if (pktValid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // transmitter credits, a send and a return may share a cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            credits <= creditT'(TX_CREDITS);
        end else begin
            case ({pktValid, txCredit})
                2'b10:   credits <= credits - creditT'(1);
                2'b01:   credits <= credits + creditT'(1);
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- hw/rewardTop.sv
`timescale 1ns/100ps

module rewardTop
    import nodePkg::*, packetPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    // from the packet filter
    input  logic     rxValid,
    input  pktTypeE  rxType,
    input  nodeIdT   rxSourceID,
    input  hopCountT rxSourceHops,
    input  qValueT   rxQValue,
    input  energyT   rxEnergy,
    input  hopCountT rxHopsFromCH,
    input  nodeIdT   rxChosenCH,
    input  logic     iAmDestination,
    output logic     rxCredit,
    // node state
    input  logic     iHaveData,
    input  nodeIdT   myNodeID,
    input  energyT   myEnergy,
    input  qValueT   myQValue,
    input  hopCountT hopsFromSink,
    input  hopCountT hopsFromCH,
    input  nodeIdT   chosenCH,
    input  nodeIdT   chosenHop,
    input  logic     lowEnergy,
    // to the transmitter
    input  logic     txCredit,
    output logic     pktValid,
    output pktTypeE  pktType,
    output nodeIdT   pktSourceID,
    output hopCountT pktSourceHops,
    output qValueT   pktQValue,
    output energyT   pktEnergy,
    output hopCountT pktHopsFromCH,
    output nodeIdT   pktChosenCH,
    output nodeIdT   pktDestID,
    output logic     txPower
);

    pktKindE  kind;
    logic     take;
    logic     load;
    logic     idle;
    logic     expired;
    logic     hbSeen;
    logic     mrTaken;
    pktTypeE  heldType;
    nodeIdT   heldSourceID;
    hopCountT heldSourceHops;
    qValueT   heldQValue;
    energyT   heldEnergy;
    hopCountT heldHopsFromCH;
    nodeIdT   heldChosenCH;

    // restart the countdown once the request is on its way
    assign mrTaken = take && (kind == MEMBER_REQ);

    membershipTimer timerInst (
        .clk     (clk),
        .nrst    (nrst),
        .idle    (idle),
        .hbSeen  (hbSeen),
        .reload  (mrTaken),
        .expired (expired)
    );

    packetClassifier classifierInst (.*);

    headerBuilder builderInst (.*);

    rewardCtrl ctrlInst (
        .clk      (clk),
        .nrst     (nrst),
        .kind     (kind),
        .txCredit (txCredit),
        .take     (take),
        .load     (load),
        .idle     (idle),
        .pktValid (pktValid),
        .rxCredit (rxCredit)
    );

endmodule

//--- test/rewardChecker.sv
`timescale 1ns/100ps

module rewardChecker
    import nodePkg::*, packetPkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     rxValid,
    input  pktTypeE  rxType,
    input  nodeIdT   rxSourceID,
    input  hopCountT rxSourceHops,
    input  qValueT   rxQValue,
    input  energyT   rxEnergy,
    input  hopCountT rxHopsFromCH,
    input  nodeIdT   rxChosenCH,
    input  logic     iAmDestination,
    input  logic     iHaveData,
    input  nodeIdT   myNodeID,
    input  energyT   myEnergy,
    input  qValueT   myQValue,
    input  hopCountT hopsFromSink,
    input  hopCountT hopsFromCH,
    input  nodeIdT   chosenCH,
    input  nodeIdT   chosenHop,
    input  logic     lowEnergy,
    input  logic     txCredit,
    input  logic     rxCredit,
    input  logic     pktValid,
    input  pktTypeE  pktType,
    input  nodeIdT   pktSourceID,
    input  hopCountT pktSourceHops,
    input  qValueT   pktQValue,
    input  energyT   pktEnergy,
    input  hopCountT pktHopsFromCH,
    input  nodeIdT   pktChosenCH,
    input  nodeIdT   pktDestID,
    input  logic     txPower,
    output int       errorCount,
    output int       checkCount,
    output int       pktCount,
    output int       mrCount,
    output int       pending
);

    // what the model expects for one consumed source
    localparam logic [1:0] EXP_DROP = 2'd0;
    localparam logic [1:0] EXP_RX   = 2'd1;
    localparam logic [1:0] EXP_OWN  = 2'd2;

    typedef struct packed {
        logic [1:0]  tag;
        logic [2:0]  pType;
        logic [15:0] source;
        logic [15:0] sourceHops;
        logic [15:0] qValue;
        logic [15:0] energy;
        logic [15:0] hopsCH;
        logic [15:0] chosen;
        logic [15:0] dest;
        logic        power;
    } expectT;

    expectT expQ[$];
    // heartbeat lock as the model sees it
    logic   lockModel;
    string  testName;
    nodeIdT nextHop;
    // packets the transmitter has not released yet
    int     outstanding;

    assign nextHop = (hopsFromSink == 16'd1) ? SINK_ID : chosenHop;

    initial begin
        errorCount  = 0;
        checkCount  = 0;
        pktCount    = 0;
        mrCount     = 0;
        pending     = 0;
        outstanding = 0;
        lockModel   = 1'b0;
        testName    = "none";
    end

    // node's own header for own data and membership requests
    function automatic expectT ownHeader();
        expectT e;
        e.tag        = EXP_OWN;
        e.pType      = lowEnergy ? 3'(SOS) : 3'(DATA);
        e.source     = myNodeID;
        e.sourceHops = hopsFromSink;
        e.qValue     = myQValue;
        e.energy     = myEnergy;
        e.hopsCH     = hopsFromCH;
        e.chosen     = chosenCH;
        e.dest       = nextHop;
        e.power      = 1'b0;
        return e;
    endfunction

    // received fields as they arrive with the destination still open
    function automatic expectT rxHeader();
        expectT e;
        e.tag        = EXP_RX;
        e.pType      = 3'(rxType);
        e.source     = rxSourceID;
        e.sourceHops = rxSourceHops;
        e.qValue     = rxQValue;
        e.energy     = rxEnergy;
        e.hopsCH     = rxHopsFromCH;
        e.chosen     = rxChosenCH;
        e.dest       = nextHop;
        e.power      = 1'b0;
        return e;
    endfunction

    task automatic compareField(string name, logic [15:0] exp, logic [15:0] act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("[ERROR] %s %s: expected %h actual %h", testName, name, exp, act);
        end
    endtask

    task automatic comparePacket(expectT e);
        compareField("pktType", 16'(e.pType), 16'(pktType));
        compareField("pktSourceID", e.source, pktSourceID);
        compareField("pktSourceHops", e.sourceHops, pktSourceHops);
        compareField("pktQValue", e.qValue, pktQValue);
        compareField("pktEnergy", e.energy, pktEnergy);
        compareField("pktHopsFromCH", e.hopsCH, pktHopsFromCH);
        compareField("pktChosenCH", e.chosen, pktChosenCH);
        compareField("pktDestID", e.dest, pktDestID);
        compareField("txPower", 16'(e.power), 16'(txPower));
    endtask

    // everything sampled at the falling edge well away from both drive times
    always @(negedge clk) begin
        expectT e;
        logic   creditUsed;
        creditUsed = 1'b0;
        if (!nrst) begin
            expQ.delete();
            lockModel   = 1'b0;
            outstanding = 0;
        end else begin
            if (pktValid) begin
                pktCount++;
                outstanding++;
                if (outstanding > int'(TX_CREDITS)) begin
                    errorCount++;
                    $display("[ERROR] %s packets outstanding: expected at most %0d actual %0d",
                             testName, TX_CREDITS, outstanding);
                end
                if (pktType == MR) begin
                    // request can slip in anywhere, so check against the template
                    mrCount++;
                    e       = ownHeader();
                    e.pType = 3'(MR);
                    e.dest  = chosenCH;
                    e.power = (hopsFromCH > 16'd1);
                    comparePacket(e);
                end else if (expQ.size() == 0) begin
                    errorCount++;
                    $display("%s: a packet went out that the model did not expect", testName);
                end else begin
                    e = expQ.pop_front();
                    if (e.tag == EXP_DROP) begin
                        errorCount++;
                        $display("%s: a packet went out for an event that should be dropped",
                                 testName);
                    end else begin
                        comparePacket(e);
                        compareField("rxCredit", 16'(e.tag == EXP_RX), 16'(rxCredit));
                        creditUsed = (e.tag == EXP_RX);
                    end
                end
            end
            // a credit only frees room from the next cycle on
            if (txCredit) begin
                outstanding--;
            end
            // credit without a packet of its own belongs to a drop
            if (rxCredit && !creditUsed) begin
                if (expQ.size() == 0 || expQ[0].tag != EXP_DROP) begin
                    errorCount++;
                    $display("%s: upstream credit returned without a dropped event", testName);
                end else begin
                    void'(expQ.pop_front());
                    checkCount++;
                end
            end
            if (rxValid) begin
                e = rxHeader();
                case (rxType)
                    HB: begin
                        e.tag        = lockModel ? EXP_DROP : EXP_RX;
                        e.sourceHops = hopsFromSink + 16'd1;
                        e.dest       = BROADCAST_ID;
                        lockModel    = 1'b1;
                    end
                    INV: begin
                        e.tag    = (rxHopsFromCH < 16'(INV_HOP_LIMIT)) ? EXP_RX : EXP_DROP;
                        e.hopsCH = rxHopsFromCH + 16'd1;
                        e.dest   = BROADCAST_ID;
                    end
                    DATA, SOS: begin
                        e.tag = iAmDestination ? EXP_RX : EXP_DROP;
                        // any data starts a new round
                        if (rxType == DATA) begin
                            lockModel = 1'b0;
                        end
                    end
                    default: e.tag = EXP_DROP;
                endcase
                expQ.push_back(e);
            end
            if (iHaveData) begin
                expQ.push_back(ownHeader());
            end
        end
        pending = expQ.size();
    end

endmodule

//--- test/rewardTb.sv
`timescale 1ns/100ps

module rewardTb
    import nodePkg::*, packetPkg::*;
();

    logic     clk;
    logic     nrst;
    logic     rxValid;
    pktTypeE  rxType;
    nodeIdT   rxSourceID;
    hopCountT rxSourceHops;
    qValueT   rxQValue;
    energyT   rxEnergy;
    hopCountT rxHopsFromCH;
    nodeIdT   rxChosenCH;
    logic     iAmDestination;
    logic     rxCredit;
    logic     iHaveData;
    nodeIdT   myNodeID;
    energyT   myEnergy;
    qValueT   myQValue;
    hopCountT hopsFromSink;
    hopCountT hopsFromCH;
    nodeIdT   chosenCH;
    nodeIdT   chosenHop;
    logic     lowEnergy;
    logic     txCredit;
    logic     pktValid;
    pktTypeE  pktType;
    nodeIdT   pktSourceID;
    hopCountT pktSourceHops;
    qValueT   pktQValue;
    energyT   pktEnergy;
    hopCountT pktHopsFromCH;
    nodeIdT   pktChosenCH;
    nodeIdT   pktDestID;
    logic     txPower;

    int errorCount;
    int checkCount;
    int pktCount;
    int mrCount;
    int pending;

    logic [31:0] rngState = 32'd75174;
    int          timeoutCount = 0;
    int          testCount = 0;
    int          failsBefore;
    int          cycleNum = 0;
    // upstream credit held by the packet filter side
    logic        upCredit;
    // cycles at which the transmitter returns its credits
    logic        holdCredits;
    int          returnQ[$];

    rewardTop rewardTop_inst (.*);

    rewardChecker checkerInst (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    always @(negedge clk) begin
        if (!nrst) begin
            upCredit = 1'b1;
            returnQ.delete();
        end else begin
            if (rxCredit) begin
                upCredit = 1'b1;
            end
            // finished with the packet 0 to 6 cycles later
            if (pktValid) begin
                returnQ.push_back(cycleNum + int'(nextRandom() % 7));
            end
        end
    end

    always @(posedge clk) begin
        cycleNum++;
        #2;
        txCredit = 1'b0;
        if (nrst && !holdCredits && returnQ.size() != 0 && returnQ[0] <= cycleNum) begin
            txCredit = 1'b1;
            void'(returnQ.pop_front());
        end
    end

    task automatic resetDut();
        nrst           = 1'b0;
        rxValid        = 1'b0;
        iHaveData      = 1'b0;
        iAmDestination = 1'b0;
        holdCredits    = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;
    endtask

    // fresh node identity, then a reset so lock and timer start clean
    task automatic setupNode(hopCountT sinkHops, hopCountT chHops);
        myNodeID     = 16'(nextRandom());
        myEnergy     = 16'(nextRandom());
        myQValue     = 16'(nextRandom());
        chosenCH     = 16'(nextRandom());
        chosenHop    = 16'(nextRandom());
        hopsFromSink = sinkHops;
        hopsFromCH   = chHops;
        lowEnergy    = 1'b0;
        resetDut();
    endtask

    task automatic waitUpCredit(input int limit, output bit ok);
        int n;
        n = 0;
        while (!upCredit && n < limit) begin
            @(posedge clk);
            n++;
        end
        ok = upCredit;
    endtask

    task automatic waitQuiet(int limit);
        int n;
        n = 0;
        while (pending != 0 && n < limit) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (pending != 0) begin
            timeoutCount++;
            $display("%s: timeout, %0d expected results never arrived",
                     checkerInst.testName, pending);
        end
    endtask

    task automatic sendEvent(pktTypeE t, hopCountT chHops, logic forMe);
        bit ok;
        waitUpCredit(40, ok);
        if (!ok) begin
            timeoutCount++;
            $display("%s: timeout, upstream credit never came back", checkerInst.testName);
        end else begin
            @(posedge clk);
            #2;
            rxValid        = 1'b1;
            rxType         = t;
            rxSourceID     = 16'(nextRandom());
            rxSourceHops   = 16'(nextRandom() % 9);
            rxQValue       = 16'(nextRandom());
            rxEnergy       = 16'(nextRandom());
            rxHopsFromCH   = chHops;
            rxChosenCH     = 16'(nextRandom());
            iAmDestination = forMe;
            upCredit       = 1'b0;
            @(posedge clk);
            #2;
            rxValid = 1'b0;
        end
    endtask

    task automatic pulseOwnData(logic low);
        @(posedge clk);
        #2;
        lowEnergy = low;
        iHaveData = 1'b1;
        @(posedge clk);
        #2;
        iHaveData = 1'b0;
    endtask

    task automatic startTest(string name);
        checkerInst.testName = name;
        failsBefore = errorCount + timeoutCount;
        testCount++;
    endtask

    task automatic endTest();
        $display("test %s finished with %0d errors", checkerInst.testName,
                 errorCount + timeoutCount - failsBefore);
    endtask

    initial begin
        int mr0;
        int n;
        bit ok;
        rxType       = HB;
        rxSourceID   = '0;
        rxSourceHops = '0;
        rxQValue     = '0;
        rxEnergy     = '0;
        rxHopsFromCH = '0;
        rxChosenCH   = '0;
        txCredit     = 1'b0;
        setupNode(16'd2, 16'd2);

        // lock sets on ripple, data clears it
        startTest("hbLock");
        sendEvent(HB, 16'd1, 1'b0);
        waitQuiet(40);
        sendEvent(HB, 16'd1, 1'b0);
        waitQuiet(40);
        sendEvent(DATA, 16'd1, 1'b0);
        waitQuiet(40);
        sendEvent(HB, 16'd2, 1'b0);
        waitQuiet(40);
        endTest();

        startTest("invRipple");
        setupNode(16'd3, 16'd1);
        repeat (12) begin
            sendEvent(INV, 16'(nextRandom() % 8), 1'b0);
            waitQuiet(40);
        end
        endTest();

        // both next hop cases
        startTest("forward");
        for (int s = 0; s < 2; s++) begin
            setupNode((s == 0) ? 16'd1 : 16'd4, 16'd2);
            repeat (8) begin
                sendEvent(nextRandom() % 2 ? SOS : DATA, 16'd0, 1'(nextRandom()));
                waitQuiet(40);
            end
        end
        endTest();

        startTest("ownData");
        setupNode(16'd2, 16'd2);
        repeat (8) begin
            pulseOwnData(1'(nextRandom()));
            waitQuiet(40);
        end
        endTest();

        // near and far cluster head for the power rule
        startTest("memberReq");
        for (int s = 0; s < 2; s++) begin
            setupNode(16'd2, (s == 0) ? 16'd1 : 16'd3);
            sendEvent(HB, 16'd0, 1'b0);
            waitQuiet(40);
            mr0 = mrCount;
            n   = 0;
            while (mrCount == mr0 && n < int'(TIMEOUT_RELOAD) + 10) begin
                @(posedge clk);
                #2;
                n++;
            end
            if (mrCount == mr0) begin
                timeoutCount++;
                $display("memberReq: no membership request within %0d cycles", n);
            end
        end
        endTest();

        // third packet has to sit in SEND until a credit comes back
        startTest("backPressure");
        setupNode(16'd2, 16'd2);
        holdCredits = 1'b1;
        for (int i = 0; i < 4; i++) begin
            waitUpCredit(20, ok);
            if (ok) begin
                sendEvent(INV, 16'd0, 1'b0);
            end
        end
        repeat (20) @(posedge clk);
        holdCredits = 1'b0;
        waitQuiet(100);
        endTest();

        startTest("randomRun");
        setupNode(16'(1 + nextRandom() % 3), 16'(1 + nextRandom() % 3));
        repeat (300) begin
            if (nextRandom() % 5 == 0) begin
                pulseOwnData(1'(nextRandom()));
            end else begin
                sendEvent(pktTypeE'(nextRandom() % 8), 16'(nextRandom() % 6),
                          1'(nextRandom()));
            end
            waitQuiet(80);
        end
        endTest();

        $display("tests %0d, checks %0d, packets %0d, requests %0d, errors %0d",
                 testCount, checkCount, pktCount, mrCount, errorCount + timeoutCount);
        if (errorCount + timeoutCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- src.f
hw/nodePkg.sv
hw/packetPkg.sv
hw/membershipTimer.sv
hw/packetClassifier.sv
hw/headerBuilder.sv
hw/rewardCtrl.sv
hw/rewardTop.sv
test/rewardChecker.sv
test/rewardTb.sv

//--- Makefile
SIM = obj_dir/rewardSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module rewardTb -f src.f \
		-Mdir obj_dir -o rewardSim

run: compile
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
